// ==== trdb_cpu_pkg.sv ====
/*
 * core-side widths, privilege levels and the
 * opcodes the encoder has to recognise
 */

package trdb_cpu_pkg;

    localparam int unsigned XLEN      = 32; // address and data width
    localparam int unsigned CAUSE_LEN = 5;  // exception cause width
    localparam int unsigned PRIV_LEN  = 2;  // privilege level width
    localparam int unsigned INST_LEN  = 32; // uncompressed instructions only

    // privilege levels, encoded as the core drives priv_lvl
    typedef enum logic [PRIV_LEN-1:0] {
        PRIV_U  = 2'b00, // user
        PRIV_S  = 2'b01, // supervisor
        PRIV_VS = 2'b10, // virtual supervisor
        PRIV_M  = 2'b11  // machine
    } priv_lvl_e;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // beq, bne, blt, bge, bltu, bgeu
    localparam logic [6:0] OPC_JALR   = 7'b1100111; // target not inferable from the binary

endpackage

// ==== trdb_pkt_pkg.sv ====
/*
 * packet types, payload layout and lengths,
 * branch map and resync limits
 */

package trdb_pkt_pkg;

    import trdb_cpu_pkg::*;

    localparam int unsigned BRANCH_MAP_LEN = 31; // outcomes held before a forced F1
    localparam int unsigned BRANCH_CNT_LEN = 5;  // holds 0..31
    localparam int unsigned RESYNC_MAX     = 8;  // packets between two sync packets

    typedef enum logic [1:0] {
        PKT_F1_BRANCH = 2'h0, // full branch map
        PKT_F2_ADDR   = 2'h1, // address after an uninferable jump
        PKT_F3_START  = 2'h2, // sync, start or resync
        PKT_F3_TRAP   = 2'h3  // sync after exception or interrupt
    } packet_type_e;

    localparam int unsigned PAYLOAD_LEN = 80;

    // one payload word, read as sync or as branch info depending on type
    typedef union packed {
        struct packed {
            priv_lvl_e              priv;
            logic                   thaddr;    // iaddr is a trap handler address
            logic                   interrupt;
            logic [CAUSE_LEN-1:0]   ecause;
            logic [XLEN-1:0]        iaddr;
            logic [XLEN-1:0]        tval;
            logic [PAYLOAD_LEN-PRIV_LEN-CAUSE_LEN-2*XLEN-3:0] pad;
        } sync;   // F3
        struct packed {
            logic [BRANCH_CNT_LEN-1:0] branches;   // valid bits in branch_map
            logic [BRANCH_MAP_LEN-1:0] branch_map; // 1 = not taken
            logic [XLEN-1:0]           iaddr;      // zero for F1
            logic [PAYLOAD_LEN-BRANCH_CNT_LEN-BRANCH_MAP_LEN-XLEN-1:0] pad;
        } branch; // F1 and F2
    } packet_payload_u;

    // packet length in bytes
    localparam int unsigned PLEN_LEN = 4;

    localparam logic [PLEN_LEN-1:0] LEN_F1       = 4'd5;  // count + map
    localparam logic [PLEN_LEN-1:0] LEN_F2       = 4'd9;  // count + map + address
    localparam logic [PLEN_LEN-1:0] LEN_F3_START = 4'd5;  // priv + address
    localparam logic [PLEN_LEN-1:0] LEN_F3_TRAP  = 4'd10; // plus cause and tval

endpackage

// ==== trdb_hist_if.sv ====
/*
 * instruction history, this cycle (tc) and last cycle (lc),
 * plus the step strobe that moves it
 */

interface trdb_hist_if import trdb_cpu_pkg::*; ();

    logic                   step;           // history advances on this edge

    // this cycle
    logic                   tc_qualified;
    logic [XLEN-1:0]        tc_iaddr;
    priv_lvl_e              tc_priv;
    logic                   tc_branch;      // conditional branch
    logic                   tc_taken;       // resolved from the nc address

    // last cycle
    logic                   lc_qualified;
    logic                   lc_exception;
    logic                   lc_interrupt;
    logic [CAUSE_LEN-1:0]   lc_cause;
    logic [XLEN-1:0]        lc_tval;
    logic                   lc_updiscon;    // lc was a jalr

    modport pipe (
        output step, tc_qualified, tc_iaddr, tc_priv, tc_branch, tc_taken,
        output lc_qualified, lc_exception, lc_interrupt, lc_cause, lc_tval, lc_updiscon
    );

    // decision side only needs the flags
    modport pri (
        input step, tc_qualified, tc_branch, tc_taken,
        input lc_qualified, lc_exception, lc_updiscon
    );

    // payload fields
    modport emit (
        input tc_iaddr, tc_priv, lc_interrupt, lc_cause, lc_tval
    );

endinterface

// ==== trdb_inst_pipe.sv ====
/*
 * input sampling with cause/tval select by privilege,
 * nc/tc/lc history and instruction type detection
 */

module trdb_inst_pipe import trdb_cpu_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    stall_i,        // packet held by emitter
    input  logic                    trace_enable_i,
    input  logic                    inst_valid_i,
    input  logic                    iretired_i,
    input  logic                    exception_i,
    input  logic                    interrupt_i,
    input  logic [CAUSE_LEN-1:0]    ucause_i,
    input  logic [CAUSE_LEN-1:0]    scause_i,
    input  logic [CAUSE_LEN-1:0]    vscause_i,
    input  logic [CAUSE_LEN-1:0]    mcause_i,
    input  logic [XLEN-1:0]         utval_i,
    input  logic [XLEN-1:0]         stval_i,
    input  logic [XLEN-1:0]         vstval_i,
    input  logic [XLEN-1:0]         mtval_i,
    input  priv_lvl_e               priv_lvl_i,
    input  logic [INST_LEN-1:0]     inst_data_i,
    input  logic [XLEN-1:0]         pc_i,
    trdb_hist_if.pipe               hist
);

    logic                   step;
    logic [CAUSE_LEN-1:0]   cause;  // selected for the current privilege
    logic [XLEN-1:0]        tval;

    // flags, cleared by reset
    logic nc_qualified_q, nc_exception_q, nc_branch_q, nc_jalr_q;
    logic tc_qualified_q, tc_exception_q, tc_branch_q, tc_jalr_q;
    logic lc_qualified_q, lc_exception_q, lc_updiscon_q;

    // payload
    logic [XLEN-1:0]        nc_iaddr_q, tc_iaddr_q;
    priv_lvl_e              nc_priv_q, tc_priv_q;
    logic                   nc_interrupt_q, tc_interrupt_q, lc_interrupt_q;
    logic [CAUSE_LEN-1:0]   nc_cause_q, tc_cause_q, lc_cause_q;
    logic [XLEN-1:0]        nc_tval_q, tc_tval_q, lc_tval_q;

    assign step = inst_valid_i & iretired_i & ~stall_i; // one retired instr accepted

    always_comb begin
        unique case (priv_lvl_i)
            PRIV_M:  begin cause = mcause_i;  tval = mtval_i;  end
            PRIV_VS: begin cause = vscause_i; tval = vstval_i; end
            PRIV_S:  begin cause = scause_i;  tval = stval_i;  end
            default: begin cause = ucause_i;  tval = utval_i;  end // user
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            {nc_qualified_q, nc_exception_q, nc_branch_q, nc_jalr_q} <= '0;
            {tc_qualified_q, tc_exception_q, tc_branch_q, tc_jalr_q} <= '0;
            {lc_qualified_q, lc_exception_q, lc_updiscon_q}          <= '0;
        end else if (step) begin
            nc_qualified_q <= trace_enable_i;
            nc_exception_q <= exception_i;
            nc_branch_q    <= inst_data_i[6:0] == OPC_BRANCH; // decode as it enters nc
            nc_jalr_q      <= inst_data_i[6:0] == OPC_JALR;
            tc_qualified_q <= nc_qualified_q;
            tc_exception_q <= nc_exception_q;
            tc_branch_q    <= nc_branch_q;
            tc_jalr_q      <= nc_jalr_q;
            lc_qualified_q <= tc_qualified_q;
            lc_exception_q <= tc_exception_q;
            lc_updiscon_q  <= tc_jalr_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (step) begin
            nc_iaddr_q     <= pc_i;
            nc_priv_q      <= priv_lvl_i;
            nc_interrupt_q <= interrupt_i;
            nc_cause_q     <= cause;
            nc_tval_q      <= tval;
            tc_iaddr_q     <= nc_iaddr_q;
            tc_priv_q      <= nc_priv_q;
            tc_interrupt_q <= nc_interrupt_q;
            tc_cause_q     <= nc_cause_q;
            tc_tval_q      <= nc_tval_q;
            lc_interrupt_q <= tc_interrupt_q;
            lc_cause_q     <= tc_cause_q;
            lc_tval_q      <= tc_tval_q;
        end
    end

    assign hist.step         = step;
    assign hist.tc_qualified = tc_qualified_q;
    assign hist.tc_iaddr     = tc_iaddr_q;
    assign hist.tc_priv      = tc_priv_q;
    assign hist.tc_branch    = tc_branch_q;
    // taken when the next instr is not the fall-through
    assign hist.tc_taken     = tc_branch_q & (nc_iaddr_q != tc_iaddr_q + XLEN'(4));
    assign hist.lc_qualified = lc_qualified_q;
    assign hist.lc_exception = lc_exception_q;
    assign hist.lc_interrupt = lc_interrupt_q;
    assign hist.lc_cause     = lc_cause_q;
    assign hist.lc_tval      = lc_tval_q;
    assign hist.lc_updiscon  = lc_updiscon_q;

endmodule

// ==== trdb_branch_map.sv ====
/*
 * branch outcome map with entry count, flush and insert
 */

module trdb_branch_map import trdb_pkt_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        insert_i, // qualified branch in tc
    input  logic                        taken_i,
    input  logic                        flush_i,  // packet emitted on this step
    output logic [BRANCH_MAP_LEN-1:0]   map_o,
    output logic [BRANCH_CNT_LEN-1:0]   count_o
);

    logic [BRANCH_MAP_LEN-1:0] map_q;
    logic [BRANCH_CNT_LEN-1:0] count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // flush first, the insert becomes entry 0 of the new map
            map_q   <= {{(BRANCH_MAP_LEN-1){1'b0}}, insert_i & ~taken_i};
            count_q <= BRANCH_CNT_LEN'(insert_i);
        end else if (insert_i) begin
            map_q[count_q] <= ~taken_i; // 1 = not taken
            count_q        <= count_q + 1'b1;
        end
    end

    assign map_o   = map_q;
    assign count_o = count_q;

endmodule

// ==== trdb_priority.sv ====
/*
 * packet type decision for the tc instruction
 * and the resync counter
 */

module trdb_priority import trdb_pkt_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    trdb_hist_if.pri                    hist,
    input  logic [BRANCH_CNT_LEN-1:0]   count_i,
    output logic                        req_valid_o,
    output packet_type_e                req_type_o,
    output logic                        flush_o,
    output logic                        insert_o,
    output logic                        taken_o
);

    logic [$clog2(RESYNC_MAX+1)-1:0]    resync_cnt_q; // packets since last sync
    logic                               tc_active;    // qualified tc on a step
    logic                               resync_due;
    logic                               map_full;

    assign tc_active  = hist.step & hist.tc_qualified;
    assign resync_due = resync_cnt_q >= RESYNC_MAX;
    assign map_full   = count_i == BRANCH_CNT_LEN'(BRANCH_MAP_LEN);

    // rules in priority order
    always_comb begin
        req_valid_o = 1'b0;
        req_type_o  = PKT_F1_BRANCH;
        if (tc_active) begin
            req_valid_o = 1'b1;
            if (!hist.lc_qualified) begin
                req_type_o = PKT_F3_START;  // first qualified instr
            end else if (hist.lc_exception) begin
                req_type_o = PKT_F3_TRAP;   // tc is the handler entry
            end else if (resync_due) begin
                req_type_o = PKT_F3_START;
            end else if (hist.lc_updiscon) begin
                req_type_o = PKT_F2_ADDR;   // jalr target
            end else if (map_full) begin
                req_type_o = PKT_F1_BRANCH;
            end else begin
                req_valid_o = 1'b0;         // nothing to report
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resync_cnt_q <= '0;
        end else if (req_valid_o) begin
            if (req_type_o inside {PKT_F3_START, PKT_F3_TRAP}) begin
                resync_cnt_q <= '0; // any sync packet restarts the count
            end else begin
                resync_cnt_q <= resync_cnt_q + 1'b1;
            end
        end
    end

    // map control, flush wins and the new outcome lands at entry 0
    assign flush_o  = req_valid_o;
    assign insert_o = tc_active & hist.tc_branch;
    assign taken_o  = hist.tc_taken;

endmodule

// ==== trdb_packet_emitter.sv ====
/*
 * payload assembly per packet type, output register
 * and stall under encapsulator back-pressure
 */

module trdb_packet_emitter import trdb_pkt_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    trdb_hist_if.emit                   hist,
    input  logic                        req_valid_i,
    input  packet_type_e                req_type_i,
    input  logic [BRANCH_MAP_LEN-1:0]   map_i,
    input  logic [BRANCH_CNT_LEN-1:0]   count_i,
    input  logic                        encapsulator_ready_i,
    output logic                        packet_valid_o,
    output packet_type_e                packet_type_o,
    output logic [PLEN_LEN-1:0]         packet_length_o,
    output packet_payload_u             packet_payload_o,
    output logic                        stall_o
);

    packet_payload_u        payload_d, payload_q;
    logic [PLEN_LEN-1:0]    length_d, length_q;
    packet_type_e           type_q;
    logic                   valid_q;

    // fill the view that belongs to the requested type
    always_comb begin
        payload_d = '0;
        length_d  = LEN_F1;
        unique case (req_type_i)
            PKT_F3_START, PKT_F3_TRAP: begin
                payload_d.sync.priv  = hist.tc_priv;
                payload_d.sync.iaddr = hist.tc_iaddr;
                length_d             = LEN_F3_START;
                if (req_type_i == PKT_F3_TRAP) begin
                    payload_d.sync.thaddr    = 1'b1; // handler follows the trap
                    payload_d.sync.interrupt = hist.lc_interrupt;
                    payload_d.sync.ecause    = hist.lc_cause;
                    payload_d.sync.tval      = hist.lc_tval;
                    length_d                 = LEN_F3_TRAP;
                end
            end
            PKT_F2_ADDR: begin
                payload_d.branch.branches   = count_i;
                payload_d.branch.branch_map = map_i;
                payload_d.branch.iaddr      = hist.tc_iaddr;
                length_d                    = LEN_F2;
            end
            default: begin // F1, iaddr stays zero
                payload_d.branch.branches   = count_i;
                payload_d.branch.branch_map = map_i;
            end
        endcase
    end

    // a request only comes on a step, never while stalled
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= 1'b0;
            type_q   <= PKT_F1_BRANCH;
            length_q <= LEN_F1;
        end else if (req_valid_i) begin
            valid_q  <= 1'b1;
            type_q   <= req_type_i;
            length_q <= length_d;
        end else if (encapsulator_ready_i) begin
            valid_q  <= 1'b0; // consumed
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            payload_q <= payload_d;
        end
    end

    assign packet_valid_o   = valid_q;
    assign packet_type_o    = type_q;
    assign packet_length_o  = length_q;
    assign packet_payload_o = payload_q;
    assign stall_o          = valid_q & ~encapsulator_ready_i; // hold packet and core

endmodule

// ==== trace_debugger.sv ====
/*
 * trace encoder top level
 */

module trace_debugger import trdb_cpu_pkg::*, trdb_pkt_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    trace_enable_i,
    input  logic                    inst_valid_i,
    input  logic                    iretired_i,
    input  logic                    exception_i,
    input  logic                    interrupt_i,
    input  logic [CAUSE_LEN-1:0]    ucause_i,
    input  logic [CAUSE_LEN-1:0]    scause_i,
    input  logic [CAUSE_LEN-1:0]    vscause_i,
    input  logic [CAUSE_LEN-1:0]    mcause_i,
    input  logic [XLEN-1:0]         utval_i,
    input  logic [XLEN-1:0]         stval_i,
    input  logic [XLEN-1:0]         vstval_i,
    input  logic [XLEN-1:0]         mtval_i,
    input  priv_lvl_e               priv_lvl_i,
    input  logic [INST_LEN-1:0]     inst_data_i,
    input  logic [XLEN-1:0]         pc_i,
    input  logic                    encapsulator_ready_i,
    output logic                    packet_valid_o,
    output packet_type_e            packet_type_o,
    output logic [PLEN_LEN-1:0]     packet_length_o,
    output logic [PAYLOAD_LEN-1:0]  packet_payload_o,
    output logic                    stall_o
);

    logic                       req_valid, flush, insert, taken;
    packet_type_e               req_type;
    logic [BRANCH_MAP_LEN-1:0]  branch_map;
    logic [BRANCH_CNT_LEN-1:0]  branch_count;

    trdb_hist_if i_hist ();

    trdb_inst_pipe i_inst_pipe (
        .clk_i, .rst_ni,
        .stall_i (stall_o),
        .trace_enable_i, .inst_valid_i, .iretired_i, .exception_i, .interrupt_i,
        .ucause_i, .scause_i, .vscause_i, .mcause_i,
        .utval_i, .stval_i, .vstval_i, .mtval_i,
        .priv_lvl_i, .inst_data_i, .pc_i,
        .hist    (i_hist.pipe)
    );

    trdb_branch_map i_branch_map (
        .clk_i, .rst_ni,
        .insert_i (insert),
        .taken_i  (taken),
        .flush_i  (flush),
        .map_o    (branch_map),
        .count_o  (branch_count)
    );

    trdb_priority i_priority (
        .clk_i, .rst_ni,
        .hist        (i_hist.pri),
        .count_i     (branch_count),
        .req_valid_o (req_valid),
        .req_type_o  (req_type),
        .flush_o     (flush),
        .insert_o    (insert),
        .taken_o     (taken)
    );

    trdb_packet_emitter i_packet_emitter (
        .clk_i, .rst_ni,
        .hist        (i_hist.emit),
        .req_valid_i (req_valid),
        .req_type_i  (req_type),
        .map_i       (branch_map),
        .count_i     (branch_count),
        .encapsulator_ready_i,
        .packet_valid_o, .packet_type_o, .packet_length_o, .packet_payload_o,
        .stall_o
    );

endmodule

// ==== trace_debugger_props.sv ====
/*
 * handshake, reset and length checks, bound to the top level
 */

module trace_debugger_props import trdb_cpu_pkg::*, trdb_pkt_pkg::*; (
    input logic                     clk_i,
    input logic                     rst_ni,
    input logic                     encapsulator_ready_i,
    input logic                     packet_valid_o,
    input logic                     stall_o,
    input packet_type_e             packet_type_o,
    input logic [PLEN_LEN-1:0]      packet_length_o,
    input logic [PAYLOAD_LEN-1:0]   packet_payload_o
);

    logic [PLEN_LEN-1:0] len_exp;

    always_comb begin
        case (packet_type_o)
            PKT_F1_BRANCH: len_exp = 4'd5;
            PKT_F2_ADDR:   len_exp = 4'd9;
            PKT_F3_START:  len_exp = 4'd5;
            default:       len_exp = 4'd10; // trap
        endcase
    end

    // quiet in and right after reset
    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_ni || $rose(rst_ni) |-> !packet_valid_o && !stall_o)
        else $error("packet_valid_o or stall_o high around reset");

    a_stall_def: assert property (@(posedge clk_i) disable iff (!rst_ni)
        stall_o == (packet_valid_o && !encapsulator_ready_i))
        else $error("stall_o does not follow valid and ready");

    // held packet must not change
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        stall_o |=> packet_valid_o && $stable(packet_type_o)
            && $stable(packet_length_o) && $stable(packet_payload_o))
        else $error("packet changed while stalled");

    a_length: assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_o |-> packet_length_o == len_exp)
        else $error("packet length does not match packet type");

endmodule

bind trace_debugger trace_debugger_props i_props (.*);

// ==== tb_trace_debugger.sv ====
/*
 * clock and reset, random CPU model,
 * reference packet model and closing report
 */

module tb_trace_debugger import trdb_cpu_pkg::*, trdb_pkt_pkg::*; ();

    // one accepted instruction as the reference model sees it
    typedef struct packed {
        logic q, exc, intr, br, jalr;
        logic tk;                           // outcome the CPU model chose
        logic [CAUSE_LEN-1:0] cause;
        logic [XLEN-1:0] tval, addr;
        priv_lvl_e priv;
    } rec_t;

    typedef struct packed {
        packet_type_e t;
        logic [PLEN_LEN-1:0] len;
        logic [PAYLOAD_LEN-1:0] pl;
    } pkt_t;

    logic clk_i, rst_ni, trace_enable_i, inst_valid_i, iretired_i;
    logic exception_i, interrupt_i, encapsulator_ready_i;
    logic [CAUSE_LEN-1:0] ucause_i, scause_i, vscause_i, mcause_i;
    logic [XLEN-1:0] utval_i, stval_i, vstval_i, mtval_i, pc_i;
    priv_lvl_e priv_lvl_i;
    logic [INST_LEN-1:0] inst_data_i;
    logic packet_valid_o, stall_o;
    packet_type_e packet_type_o;
    logic [PLEN_LEN-1:0] packet_length_o;
    logic [PAYLOAD_LEN-1:0] packet_payload_o;

    rec_t nc_r, tc_r, lc_r;                 // reference history
    logic [BRANCH_MAP_LEN-1:0] map_r;
    int cnt_r, rs_r;                        // map count, packets since sync
    pkt_t exp_q[$];                         // expected packets in order
    int n_mismatch, n_proto, ready_hold;
    bit timed_out, accepted;
    logic [31:0] lfsr = 32'h5341a263;
    logic [XLEN-1:0] pc;
    logic br_taken;                         // branch on the pins jumps

    trace_debugger DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic pick_ready();
        if (ready_hold > 0) begin
            ready_hold--; // forced back-pressure window
            return 1'b0;
        end
        return rand_bits(2) != 0;
    endfunction

    function automatic string tname(input packet_type_e t);
        case (t)
            PKT_F1_BRANCH: return "f1_branch";
            PKT_F2_ADDR:   return "f2_addr";
            PKT_F3_START:  return "f3_start";
            default:       return "f3_trap";
        endcase
    endfunction

    // the instruction on the pins with cause and tval picked by privilege
    function automatic rec_t pin_rec();
        rec_t r;
        r.q = trace_enable_i;
        r.exc = exception_i;
        r.intr = interrupt_i;
        r.br = inst_data_i[6:0] == 7'b1100011;
        r.jalr = inst_data_i[6:0] == 7'b1100111;
        r.tk = br_taken;
        r.addr = pc_i;
        r.priv = priv_lvl_i;
        case (priv_lvl_i)
            PRIV_U:  begin r.cause = ucause_i;  r.tval = utval_i;  end
            PRIV_S:  begin r.cause = scause_i;  r.tval = stval_i;  end
            PRIV_VS: begin r.cause = vscause_i; r.tval = vstval_i; end
            default: begin r.cause = mcause_i;  r.tval = mtval_i;  end
        endcase
        return r;
    endfunction

    // packet rules for tc then map update then history shift
    task automatic model_step(input rec_t n);
        pkt_t e;
        packet_payload_u p;
        logic taken, send;
        taken = tc_r.br && tc_r.tk;
        send = 1'b1;
        p = '0;
        e = '0;
        if (!tc_r.q) send = 1'b0;
        else if (!lc_r.q) e.t = PKT_F3_START;
        else if (lc_r.exc) e.t = PKT_F3_TRAP;
        else if (rs_r >= 8) e.t = PKT_F3_START;
        else if (lc_r.jalr) e.t = PKT_F2_ADDR;
        else if (cnt_r == 31) e.t = PKT_F1_BRANCH;
        else send = 1'b0;
        if (send) begin
            if (e.t inside {PKT_F3_START, PKT_F3_TRAP}) begin
                p.sync.priv = tc_r.priv;
                p.sync.iaddr = tc_r.addr;
                e.len = 4'd5;
                if (e.t == PKT_F3_TRAP) begin
                    p.sync.thaddr = 1'b1;
                    p.sync.interrupt = lc_r.intr;
                    p.sync.ecause = lc_r.cause;
                    p.sync.tval = lc_r.tval;
                    e.len = 4'd10;
                end
                rs_r = 0;
            end else begin
                p.branch.branches = cnt_r[4:0];
                p.branch.branch_map = map_r;
                p.branch.iaddr = (e.t == PKT_F2_ADDR) ? tc_r.addr : '0;
                e.len = (e.t == PKT_F2_ADDR) ? 4'd9 : 4'd5;
                rs_r++;
            end
            e.pl = p;
            exp_q.push_back(e);
            map_r = '0; // flush before insert
            cnt_r = 0;
        end
        if (tc_r.q && tc_r.br) begin
            map_r[cnt_r] = !taken; // 1 = not taken
            cnt_r++;
        end
        lc_r = tc_r;
        tc_r = nc_r;
        nc_r = n;
    endtask

    task automatic check_packet();
        pkt_t e;
        if (exp_q.size() == 0) begin
            n_proto++;
            $display("packet of type %s arrived with none expected", tname(packet_type_o));
            return;
        end
        e = exp_q.pop_front();
        if (packet_type_o != e.t) begin
            n_mismatch++;
            $display("FAIL %s type: expected %h actual %h", tname(e.t), e.t, packet_type_o);
        end
        if (packet_length_o != e.len) begin
            n_mismatch++;
            $display("FAIL %s length: expected %0d actual %0d",
                     tname(e.t), e.len, packet_length_o);
        end
        if (packet_payload_o != e.pl) begin
            n_mismatch++;
            $display("FAIL %s payload: expected %h actual %h",
                     tname(e.t), e.pl, packet_payload_o);
        end
    endtask

    // pre-edge values so a packet is consumed before the next accept
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (packet_valid_o && encapsulator_ready_i) check_packet();
            if (inst_valid_i && iretired_i && !stall_o) begin
                model_step(pin_rec());
                accepted = 1'b1;
            end
        end
    end

    // one instruction from the CPU model held until accepted
    task automatic issue(input bit en, input bit only_br);
        logic [XLEN-1:0] next, r;
        logic [6:0] opc;
        logic [2:0] kind;
        int t;
        if (rand_bits(3) == 0) begin
            if (rand_bits(1) != 0) begin
                inst_valid_i = 1'b0; // bubble
            end else begin
                iretired_i = 1'b0;   // valid but not retired
            end
            @(negedge clk_i);
        end
        kind = only_br ? 3'd0 : 3'(rand_bits(3));
        exception_i = 1'b0;
        interrupt_i = 1'b0;
        br_taken = 1'b0;
        next = pc + 32'd4;
        opc = 7'h13; // alu op
        r = rand_bits(30);
        if (kind <= 2) begin
            opc = 7'b1100011;
            if (rand_bits(1) != 0) begin
                next = pc + 32'd8 + {r[3:0], 2'b00};
                br_taken = 1'b1;
            end
        end else if (kind == 3) begin
            opc = 7'b1100111;
            next = {r[29:0], 2'b00}; // jalr target
        end else if (kind == 4) begin
            exception_i = 1'b1;
            interrupt_i = rand_bits(1) != 0;
            next = {4'h8, r[25:0], 2'b00}; // handler
        end
        priv_lvl_i = priv_lvl_e'(rand_bits(2));
        ucause_i = 5'(rand_bits(5));
        scause_i = 5'(rand_bits(5));
        vscause_i = 5'(rand_bits(5));
        mcause_i = 5'(rand_bits(5));
        utval_i = rand_bits(32);
        stval_i = rand_bits(32);
        vstval_i = rand_bits(32);
        mtval_i = rand_bits(32);
        inst_data_i = {25'(rand_bits(25)), opc};
        pc_i = pc;
        trace_enable_i = en;
        inst_valid_i = 1'b1;
        iretired_i = 1'b1;
        accepted = 1'b0;
        encapsulator_ready_i = pick_ready();
        for (t = 0; t < 100 && !accepted; t++) begin
            @(negedge clk_i);
            if (!accepted) encapsulator_ready_i = pick_ready();
        end
        if (!accepted) begin
            $display("timeout: instruction at %h was never accepted", pc);
            timed_out = 1'b1;
        end
        pc = next;
    endtask

    task automatic run(input int n, input bit en, input bit only_br);
        for (int i = 0; i < n && !timed_out; i++) issue(en, only_br);
    endtask

    initial begin
        int t;
        {trace_enable_i, inst_valid_i, iretired_i, exception_i, interrupt_i} = '0;
        {ucause_i, scause_i, vscause_i, mcause_i} = '0;
        {utval_i, stval_i, vstval_i, mtval_i, inst_data_i, pc_i} = '0;
        priv_lvl_i = PRIV_M;
        encapsulator_ready_i = 1'b1;
        {nc_r, tc_r, lc_r} = '0;
        map_r = '0;
        br_taken = 1'b0;
        {cnt_r, rs_r, n_mismatch, n_proto, ready_hold} = '0;
        pc = 32'h0000_1000;
        rst_ni = 1'b0;
        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        run(6, 1'b0, 1'b0);     // untraced then start
        run(200, 1'b1, 1'b0);
        run(4, 1'b0, 1'b0);     // gap and restart
        run(300, 1'b1, 1'b1);   // full maps and resync
        ready_hold = 20;        // long back-pressure
        run(160, 1'b1, 1'b0);
        inst_valid_i = 1'b0;
        encapsulator_ready_i = 1'b1;
        for (t = 0; t < 100 && (exp_q.size() != 0 || packet_valid_o); t++) @(negedge clk_i);
        if (exp_q.size() != 0) begin
            n_proto++;
            $display("%0d expected packets never appeared", exp_q.size());
        end
        $display("errors: %0d mismatches, %0d protocol, %0d timeouts",
                 n_mismatch, n_proto, int'(timed_out));
        if (n_mismatch == 0 && n_proto == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== trace_debugger.f ====
trdb_cpu_pkg.sv
trdb_pkt_pkg.sv
trdb_hist_if.sv
trdb_inst_pipe.sv
trdb_branch_map.sv
trdb_priority.sv
trdb_packet_emitter.sv
trace_debugger.sv
trace_debugger_props.sv
tb_trace_debugger.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_trace_debugger
LOG       ?= sim.log
FLIST     ?= trace_debugger.f

SRCS := $(shell cat $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
